/* source/l15_bridge_consts.svh */
`ifndef L15_BRIDGE_CONSTS_SVH
`define L15_BRIDGE_CONSTS_SVH

// Queue depths
`define L15_REQ_FIFO_ELS 4
`define L15_RET_FIFO_ELS 16

// Field widths
`define L15_ADDR_W 40
`define L15_DATA_W 64
`define L15_RQTYPE_W 5
`define L15_RTNTYPE_W 4
`define L15_SIZE_W 3
`define L15_RPLWAY_W 2
`define L15_AMO_W 4
`define L15_INVAL_ADDR_W 12
`define L15_WAY_W 2

// Return type codes from the L1.5
`define L15_RTN_LOAD 4'h0
`define L15_RTN_IFILL 4'h1
`define L15_RTN_EVICT 4'h3
`define L15_RTN_ST_ACK 4'h4
`define L15_RTN_INT 4'h7
`define L15_RTN_ATOMIC 4'hd

`endif

/* source/l15_bridge_pkg.sv */
`default_nettype none
`include "l15_bridge_consts.svh"

package l15_bridge_pkg;

  // Request side fields
  typedef logic [`L15_RQTYPE_W-1:0] rqtype_t;
  typedef logic [`L15_SIZE_W-1:0] size_t;
  typedef logic [`L15_ADDR_W-1:0] paddr_t;
  typedef logic [`L15_DATA_W-1:0] dword_t;
  typedef logic [`L15_RPLWAY_W-1:0] rplway_t;
  typedef logic [`L15_AMO_W-1:0] amo_op_t;

  // Invalidation fields of a return, address bits 15..4 only
  typedef logic [`L15_INVAL_ADDR_W-1:0] inval_addr_t;
  typedef logic [`L15_WAY_W-1:0] way_t;

  // Codes not listed here still pass through the return queue
  typedef enum logic [`L15_RTNTYPE_W-1:0] {
    e_load_ret   = `L15_RTN_LOAD,
    e_ifill_ret  = `L15_RTN_IFILL,
    e_evict_req  = `L15_RTN_EVICT,
    e_st_ack     = `L15_RTN_ST_ACK,
    e_int_ret    = `L15_RTN_INT,
    e_atomic_ret = `L15_RTN_ATOMIC
  } rtntype_e;

endpackage

`default_nettype wire

/* source/l15_msg_if.sv */
`timescale 1ns/1ns
`default_nettype none

// One cache engine request toward the arbiter
interface l15_req_if;
  l15_bridge_pkg::rqtype_t rqtype;
  logic nc;
  l15_bridge_pkg::size_t size;
  l15_bridge_pkg::paddr_t address;
  l15_bridge_pkg::dword_t data;
  l15_bridge_pkg::rplway_t l1rplway;
  l15_bridge_pkg::amo_op_t amo_op;
  logic v;
  logic ready;

  modport src (output rqtype, nc, size, address, data, l1rplway, amo_op, v, input ready);
  modport dst (input rqtype, nc, size, address, data, l1rplway, amo_op, v, output ready);
endinterface

// Head of the return queue, shared by both channels
interface l15_ret_if;
  l15_bridge_pkg::rtntype_e rtntype;
  logic noncacheable;
  logic atomic;
  l15_bridge_pkg::dword_t data_0;
  l15_bridge_pkg::dword_t data_1;
  l15_bridge_pkg::dword_t data_2;
  l15_bridge_pkg::dword_t data_3;
  l15_bridge_pkg::inval_addr_t inval_address_15_4;
  logic inval_icache_inval;
  logic inval_dcache_inval;
  l15_bridge_pkg::way_t inval_way;
  logic icache_v;
  logic dcache_v;
  logic icache_yumi;
  logic dcache_yumi;

  modport src (
    output rtntype, noncacheable, atomic, data_0, data_1, data_2, data_3,
    output inval_address_15_4, inval_icache_inval, inval_dcache_inval, inval_way,
    output icache_v, dcache_v,
    input icache_yumi, dcache_yumi
  );
  modport dst (
    input rtntype, noncacheable, atomic, data_0, data_1, data_2, data_3,
    input inval_address_15_4, inval_icache_inval, inval_dcache_inval, inval_way,
    input icache_v, dcache_v,
    output icache_yumi, dcache_yumi
  );
endinterface

`default_nettype wire

/* source/bridge_fifo.sv */
`timescale 1ns/1ns
`default_nettype none

module bridge_fifo
  #(parameter int width_p = 8
    , parameter int els_p = 4
    )
  (input logic clk_i
   , input logic arst_n_i

   , input logic [width_p-1:0] data_i
   , input logic v_i
   , output logic ready_o

   , output logic [width_p-1:0] data_o
   , output logic v_o
   , input logic yumi_i
   );

  localparam int ptr_w_lp = (els_p > 1) ? $clog2(els_p) : 1;
  localparam int cnt_w_lp = $clog2(els_p + 1);

  logic [width_p-1:0] mem_r [els_p];
  logic [ptr_w_lp-1:0] wr_ptr_r;
  logic [ptr_w_lp-1:0] rd_ptr_r;
  logic [cnt_w_lp-1:0] count_r;
  logic push_li;
  logic pop_li;

  // Registered output, no bypass from data_i
  assign ready_o = (count_r != cnt_w_lp'(els_p));
  assign v_o = (count_r != '0);
  assign data_o = mem_r[rd_ptr_r];

  assign push_li = v_i & ready_o;
  assign pop_li = yumi_i;

  always_ff @(posedge clk_i) begin
    if (push_li) begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r <= '0;
    end else begin
      if (push_li) begin
        wr_ptr_r <= (wr_ptr_r == ptr_w_lp'(els_p - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (pop_li) begin
        rd_ptr_r <= (rd_ptr_r == ptr_w_lp'(els_p - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      case ({push_li, pop_li})
        2'b10: count_r <= count_r + 1'b1;
        2'b01: count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/l15_req_arbiter.sv */
`timescale 1ns/1ns
`default_nettype none
`include "l15_bridge_consts.svh"

module l15_req_arbiter
  (input logic clk_i
   , input logic arst_n_i

   , l15_req_if.dst icache_req
   , l15_req_if.dst dcache_req

   , output l15_bridge_pkg::rqtype_t l15_rqtype_o
   , output logic l15_nc_o
   , output l15_bridge_pkg::size_t l15_size_o
   , output l15_bridge_pkg::paddr_t l15_address_o
   , output l15_bridge_pkg::dword_t l15_data_o
   , output l15_bridge_pkg::rplway_t l15_l1rplway_o
   , output l15_bridge_pkg::amo_op_t l15_amo_op_o
   , output logic l15_val_o
   , input logic l15_ack_i
   );

  localparam int entry_w_lp = `L15_RQTYPE_W + 1 + `L15_SIZE_W + `L15_ADDR_W
                              + `L15_DATA_W + `L15_RPLWAY_W + `L15_AMO_W;

  logic [entry_w_lp-1:0] icache_entry_li, dcache_entry_li;
  logic [entry_w_lp-1:0] icache_head_lo, dcache_head_lo;
  logic [entry_w_lp-1:0] sel_entry_lo;
  logic icache_head_v_lo, dcache_head_v_lo;
  logic icache_yumi_li, dcache_yumi_li;
  logic icache_grant_lo, dcache_grant_lo;

  assign icache_entry_li = {icache_req.rqtype, icache_req.nc, icache_req.size,
                            icache_req.address, icache_req.data, icache_req.l1rplway,
                            icache_req.amo_op};
  assign dcache_entry_li = {dcache_req.rqtype, dcache_req.nc, dcache_req.size,
                            dcache_req.address, dcache_req.data, dcache_req.l1rplway,
                            dcache_req.amo_op};

  // Four entries per channel keep a writeback from blocking its own miss
  bridge_fifo
   #(.width_p(entry_w_lp), .els_p(`L15_REQ_FIFO_ELS))
   icache_fifo
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.data_i(icache_entry_li)
     ,.v_i(icache_req.v)
     ,.ready_o(icache_req.ready)
     ,.data_o(icache_head_lo)
     ,.v_o(icache_head_v_lo)
     ,.yumi_i(icache_yumi_li)
     );

  bridge_fifo
   #(.width_p(entry_w_lp), .els_p(`L15_REQ_FIFO_ELS))
   dcache_fifo
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.data_i(dcache_entry_li)
     ,.v_i(dcache_req.v)
     ,.ready_o(dcache_req.ready)
     ,.data_o(dcache_head_lo)
     ,.v_o(dcache_head_v_lo)
     ,.yumi_i(dcache_yumi_li)
     );

  // Data cache always wins
  assign dcache_grant_lo = dcache_head_v_lo;
  assign icache_grant_lo = icache_head_v_lo & ~dcache_head_v_lo;

  assign sel_entry_lo = dcache_grant_lo ? dcache_head_lo : icache_head_lo;

  assign {l15_rqtype_o, l15_nc_o, l15_size_o, l15_address_o,
          l15_data_o, l15_l1rplway_o, l15_amo_op_o} = sel_entry_lo;
  assign l15_val_o = icache_head_v_lo | dcache_head_v_lo;

  // Only the granted head leaves, and only once the L1.5 takes it
  assign dcache_yumi_li = dcache_grant_lo & l15_ack_i;
  assign icache_yumi_li = icache_grant_lo & l15_ack_i;

endmodule

`default_nettype wire

/* source/l15_ret_router.sv */
`timescale 1ns/1ns
`default_nettype none
`include "l15_bridge_consts.svh"

module l15_ret_router
  (input logic clk_i
   , input logic arst_n_i

   , input logic l15_val_i
   , input l15_bridge_pkg::rtntype_e l15_returntype_i
   , input logic l15_noncacheable_i
   , input logic l15_atomic_i
   , input l15_bridge_pkg::dword_t l15_data_0_i
   , input l15_bridge_pkg::dword_t l15_data_1_i
   , input l15_bridge_pkg::dword_t l15_data_2_i
   , input l15_bridge_pkg::dword_t l15_data_3_i
   , input l15_bridge_pkg::inval_addr_t l15_inval_address_15_4_i
   , input logic l15_inval_icache_inval_i
   , input logic l15_inval_dcache_inval_i
   , input l15_bridge_pkg::way_t l15_inval_way_i
   , output logic l15_req_ack_o

   , l15_ret_if.src ret
   );

  localparam int entry_w_lp = `L15_RTNTYPE_W + 2 + 4 * `L15_DATA_W
                              + `L15_INVAL_ADDR_W + 2 + `L15_WAY_W;

  logic [entry_w_lp-1:0] entry_li, head_lo;
  logic [`L15_RTNTYPE_W-1:0] head_rtntype_lo;
  l15_bridge_pkg::rtntype_e head_type_lo;
  logic fifo_ready_lo;
  logic head_v_lo;
  logic pop_li;
  logic dcache_only_lo;
  logic icache_only_lo;

  assign entry_li = {l15_returntype_i, l15_noncacheable_i, l15_atomic_i,
                     l15_data_0_i, l15_data_1_i, l15_data_2_i, l15_data_3_i,
                     l15_inval_address_15_4_i, l15_inval_icache_inval_i,
                     l15_inval_dcache_inval_i, l15_inval_way_i};

  bridge_fifo
   #(.width_p(entry_w_lp), .els_p(`L15_RET_FIFO_ELS))
   ret_fifo
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.data_i(entry_li)
     ,.v_i(l15_val_i)
     ,.ready_o(fifo_ready_lo)
     ,.data_o(head_lo)
     ,.v_o(head_v_lo)
     ,.yumi_i(pop_li)
     );

  // Acknowledge in the same cycle the entry is written
  assign l15_req_ack_o = l15_val_i & fifo_ready_lo;

  assign {head_rtntype_lo, ret.noncacheable, ret.atomic,
          ret.data_0, ret.data_1, ret.data_2, ret.data_3,
          ret.inval_address_15_4, ret.inval_icache_inval,
          ret.inval_dcache_inval, ret.inval_way} = head_lo;

  assign head_type_lo = l15_bridge_pkg::rtntype_e'(head_rtntype_lo);
  assign ret.rtntype = head_type_lo;

  // Steering by return type, anything unlisted goes to both sides
  assign dcache_only_lo = (head_type_lo == l15_bridge_pkg::e_load_ret)
                        | (head_type_lo == l15_bridge_pkg::e_st_ack)
                        | (head_type_lo == l15_bridge_pkg::e_atomic_ret);
  assign icache_only_lo = (head_type_lo == l15_bridge_pkg::e_ifill_ret);

  assign ret.icache_v = head_v_lo & ~dcache_only_lo;
  assign ret.dcache_v = head_v_lo & ~icache_only_lo;

  // A broadcast return leaves on the first yumi
  assign pop_li = ret.icache_yumi | ret.dcache_yumi;

endmodule

`default_nettype wire

/* source/l15_bridge_top.sv */
`timescale 1ns/1ns
`default_nettype none

module l15_bridge_top
  (input logic clk_i
   , input logic arst_n_i

   // Instruction cache request channel
   , input l15_bridge_pkg::rqtype_t icache_req_rqtype_i
   , input logic icache_req_nc_i
   , input l15_bridge_pkg::size_t icache_req_size_i
   , input l15_bridge_pkg::paddr_t icache_req_address_i
   , input l15_bridge_pkg::dword_t icache_req_data_i
   , input l15_bridge_pkg::rplway_t icache_req_l1rplway_i
   , input l15_bridge_pkg::amo_op_t icache_req_amo_op_i
   , input logic icache_req_v_i
   , output logic icache_req_ready_o

   // Data cache request channel
   , input l15_bridge_pkg::rqtype_t dcache_req_rqtype_i
   , input logic dcache_req_nc_i
   , input l15_bridge_pkg::size_t dcache_req_size_i
   , input l15_bridge_pkg::paddr_t dcache_req_address_i
   , input l15_bridge_pkg::dword_t dcache_req_data_i
   , input l15_bridge_pkg::rplway_t dcache_req_l1rplway_i
   , input l15_bridge_pkg::amo_op_t dcache_req_amo_op_i
   , input logic dcache_req_v_i
   , output logic dcache_req_ready_o

   // Toward the L1.5
   , output l15_bridge_pkg::rqtype_t l15_rqtype_o
   , output logic l15_nc_o
   , output l15_bridge_pkg::size_t l15_size_o
   , output l15_bridge_pkg::paddr_t l15_address_o
   , output l15_bridge_pkg::dword_t l15_data_o
   , output l15_bridge_pkg::rplway_t l15_l1rplway_o
   , output l15_bridge_pkg::amo_op_t l15_amo_op_o
   , output logic l15_val_o
   , input logic l15_ack_i

   // From the L1.5
   , input logic l15_val_i
   , input l15_bridge_pkg::rtntype_e l15_returntype_i
   , input logic l15_noncacheable_i
   , input logic l15_atomic_i
   , input l15_bridge_pkg::dword_t l15_data_0_i
   , input l15_bridge_pkg::dword_t l15_data_1_i
   , input l15_bridge_pkg::dword_t l15_data_2_i
   , input l15_bridge_pkg::dword_t l15_data_3_i
   , input l15_bridge_pkg::inval_addr_t l15_inval_address_15_4_i
   , input logic l15_inval_icache_inval_i
   , input logic l15_inval_dcache_inval_i
   , input l15_bridge_pkg::way_t l15_inval_way_i
   , output logic l15_req_ack_o

   // Queued return toward the cache engines
   , output l15_bridge_pkg::rtntype_e ret_rtntype_o
   , output logic ret_noncacheable_o
   , output logic ret_atomic_o
   , output l15_bridge_pkg::dword_t ret_data_0_o
   , output l15_bridge_pkg::dword_t ret_data_1_o
   , output l15_bridge_pkg::dword_t ret_data_2_o
   , output l15_bridge_pkg::dword_t ret_data_3_o
   , output l15_bridge_pkg::inval_addr_t ret_inval_address_15_4_o
   , output logic ret_inval_icache_inval_o
   , output logic ret_inval_dcache_inval_o
   , output l15_bridge_pkg::way_t ret_inval_way_o
   , output logic icache_ret_v_o
   , output logic dcache_ret_v_o
   , input logic icache_ret_yumi_i
   , input logic dcache_ret_yumi_i
   );

  l15_req_if icache_req_if ();
  l15_req_if dcache_req_if ();
  l15_ret_if ret_if ();

  assign icache_req_if.rqtype = icache_req_rqtype_i;
  assign icache_req_if.nc = icache_req_nc_i;
  assign icache_req_if.size = icache_req_size_i;
  assign icache_req_if.address = icache_req_address_i;
  assign icache_req_if.data = icache_req_data_i;
  assign icache_req_if.l1rplway = icache_req_l1rplway_i;
  assign icache_req_if.amo_op = icache_req_amo_op_i;
  assign icache_req_if.v = icache_req_v_i;
  assign icache_req_ready_o = icache_req_if.ready;

  assign dcache_req_if.rqtype = dcache_req_rqtype_i;
  assign dcache_req_if.nc = dcache_req_nc_i;
  assign dcache_req_if.size = dcache_req_size_i;
  assign dcache_req_if.address = dcache_req_address_i;
  assign dcache_req_if.data = dcache_req_data_i;
  assign dcache_req_if.l1rplway = dcache_req_l1rplway_i;
  assign dcache_req_if.amo_op = dcache_req_amo_op_i;
  assign dcache_req_if.v = dcache_req_v_i;
  assign dcache_req_ready_o = dcache_req_if.ready;

  l15_req_arbiter
   u_req_arbiter
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.icache_req(icache_req_if)
     ,.dcache_req(dcache_req_if)
     ,.l15_rqtype_o(l15_rqtype_o)
     ,.l15_nc_o(l15_nc_o)
     ,.l15_size_o(l15_size_o)
     ,.l15_address_o(l15_address_o)
     ,.l15_data_o(l15_data_o)
     ,.l15_l1rplway_o(l15_l1rplway_o)
     ,.l15_amo_op_o(l15_amo_op_o)
     ,.l15_val_o(l15_val_o)
     ,.l15_ack_i(l15_ack_i)
     );

  l15_ret_router
   u_ret_router
    (.clk_i(clk_i)
     ,.arst_n_i(arst_n_i)
     ,.l15_val_i(l15_val_i)
     ,.l15_returntype_i(l15_returntype_i)
     ,.l15_noncacheable_i(l15_noncacheable_i)
     ,.l15_atomic_i(l15_atomic_i)
     ,.l15_data_0_i(l15_data_0_i)
     ,.l15_data_1_i(l15_data_1_i)
     ,.l15_data_2_i(l15_data_2_i)
     ,.l15_data_3_i(l15_data_3_i)
     ,.l15_inval_address_15_4_i(l15_inval_address_15_4_i)
     ,.l15_inval_icache_inval_i(l15_inval_icache_inval_i)
     ,.l15_inval_dcache_inval_i(l15_inval_dcache_inval_i)
     ,.l15_inval_way_i(l15_inval_way_i)
     ,.l15_req_ack_o(l15_req_ack_o)
     ,.ret(ret_if)
     );

  // Both engines see the same head fields
  assign ret_rtntype_o = ret_if.rtntype;
  assign ret_noncacheable_o = ret_if.noncacheable;
  assign ret_atomic_o = ret_if.atomic;
  assign ret_data_0_o = ret_if.data_0;
  assign ret_data_1_o = ret_if.data_1;
  assign ret_data_2_o = ret_if.data_2;
  assign ret_data_3_o = ret_if.data_3;
  assign ret_inval_address_15_4_o = ret_if.inval_address_15_4;
  assign ret_inval_icache_inval_o = ret_if.inval_icache_inval;
  assign ret_inval_dcache_inval_o = ret_if.inval_dcache_inval;
  assign ret_inval_way_o = ret_if.inval_way;
  assign icache_ret_v_o = ret_if.icache_v;
  assign dcache_ret_v_o = ret_if.dcache_v;
  assign ret_if.icache_yumi = icache_ret_yumi_i;
  assign ret_if.dcache_yumi = dcache_ret_yumi_i;

endmodule

`default_nettype wire

/* tests/tb_l15_bridge.sv */
`timescale 1ns/1ns
`default_nettype none
`include "l15_bridge_consts.svh"

module tb_l15_bridge;

  typedef struct packed {
    l15_bridge_pkg::rqtype_t rqtype;
    logic nc;
    l15_bridge_pkg::size_t size;
    l15_bridge_pkg::paddr_t address;
    l15_bridge_pkg::dword_t data;
    l15_bridge_pkg::rplway_t l1rplway;
    l15_bridge_pkg::amo_op_t amo_op;
  } req_t;

  typedef struct packed {
    l15_bridge_pkg::rtntype_e rtntype;
    logic noncacheable;
    logic atomic;
    l15_bridge_pkg::dword_t [3:0] data;
    l15_bridge_pkg::inval_addr_t inval_addr;
    logic inval_icache;
    logic inval_dcache;
    l15_bridge_pkg::way_t inval_way;
  } ret_t;

  logic clk, arst_n;
  req_t icache_in, dcache_in;
  logic icache_v, dcache_v, icache_ready, dcache_ready;
  l15_bridge_pkg::rqtype_t l15_rqtype;
  logic l15_nc, l15_val, ack;
  l15_bridge_pkg::size_t l15_size;
  l15_bridge_pkg::paddr_t l15_address;
  l15_bridge_pkg::dword_t l15_data;
  l15_bridge_pkg::rplway_t l15_l1rplway;
  l15_bridge_pkg::amo_op_t l15_amo_op;
  ret_t ret_in;
  logic l15_ret_v, l15_req_ack;
  l15_bridge_pkg::rtntype_e ret_rtntype;
  logic ret_nc, ret_atomic, ret_iinv, ret_dinv;
  l15_bridge_pkg::dword_t ret_data [4];
  l15_bridge_pkg::inval_addr_t ret_iaddr;
  l15_bridge_pkg::way_t ret_way;
  logic icache_ret_v, dcache_ret_v, icache_yumi, dcache_yumi;

  req_t icache_exp [$];
  req_t dcache_exp [$];
  ret_t ret_exp [$];
  logic [31:0] lfsr_state = 32'h2003b1d0;
  int cycle_count = 0;
  // Every listed code plus one unlisted code
  logic [3:0] type_codes [7] = '{`L15_RTN_LOAD, `L15_RTN_IFILL, `L15_RTN_EVICT,
                                 `L15_RTN_ST_ACK, `L15_RTN_INT, `L15_RTN_ATOMIC, 4'h2};

  l15_bridge_top u_l15_bridge_top
    (.clk_i(clk), .arst_n_i(arst_n)
     ,.icache_req_rqtype_i(icache_in.rqtype), .icache_req_nc_i(icache_in.nc)
     ,.icache_req_size_i(icache_in.size), .icache_req_address_i(icache_in.address)
     ,.icache_req_data_i(icache_in.data), .icache_req_l1rplway_i(icache_in.l1rplway)
     ,.icache_req_amo_op_i(icache_in.amo_op), .icache_req_v_i(icache_v)
     ,.icache_req_ready_o(icache_ready)
     ,.dcache_req_rqtype_i(dcache_in.rqtype), .dcache_req_nc_i(dcache_in.nc)
     ,.dcache_req_size_i(dcache_in.size), .dcache_req_address_i(dcache_in.address)
     ,.dcache_req_data_i(dcache_in.data), .dcache_req_l1rplway_i(dcache_in.l1rplway)
     ,.dcache_req_amo_op_i(dcache_in.amo_op), .dcache_req_v_i(dcache_v)
     ,.dcache_req_ready_o(dcache_ready)
     ,.l15_rqtype_o(l15_rqtype), .l15_nc_o(l15_nc), .l15_size_o(l15_size)
     ,.l15_address_o(l15_address), .l15_data_o(l15_data), .l15_l1rplway_o(l15_l1rplway)
     ,.l15_amo_op_o(l15_amo_op), .l15_val_o(l15_val), .l15_ack_i(ack)
     ,.l15_val_i(l15_ret_v), .l15_returntype_i(ret_in.rtntype)
     ,.l15_noncacheable_i(ret_in.noncacheable), .l15_atomic_i(ret_in.atomic)
     ,.l15_data_0_i(ret_in.data[0]), .l15_data_1_i(ret_in.data[1])
     ,.l15_data_2_i(ret_in.data[2]), .l15_data_3_i(ret_in.data[3])
     ,.l15_inval_address_15_4_i(ret_in.inval_addr)
     ,.l15_inval_icache_inval_i(ret_in.inval_icache)
     ,.l15_inval_dcache_inval_i(ret_in.inval_dcache)
     ,.l15_inval_way_i(ret_in.inval_way), .l15_req_ack_o(l15_req_ack)
     ,.ret_rtntype_o(ret_rtntype), .ret_noncacheable_o(ret_nc), .ret_atomic_o(ret_atomic)
     ,.ret_data_0_o(ret_data[0]), .ret_data_1_o(ret_data[1])
     ,.ret_data_2_o(ret_data[2]), .ret_data_3_o(ret_data[3])
     ,.ret_inval_address_15_4_o(ret_iaddr), .ret_inval_icache_inval_o(ret_iinv)
     ,.ret_inval_dcache_inval_o(ret_dinv), .ret_inval_way_o(ret_way)
     ,.icache_ret_v_o(icache_ret_v), .dcache_ret_v_o(dcache_ret_v)
     ,.icache_ret_yumi_i(icache_yumi), .dcache_ret_yumi_i(dcache_yumi)
     );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= 3000) begin
      stop_with_failure("Timeout, the tests did not finish within 3000 cycles");
    end
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  // Taps 32, 22, 2, 1 and one step per bit taken
  function automatic logic [63:0] take_bits(input int n);
    logic [63:0] val;
    logic fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      val = {val[62:0], fb};
    end
    return val;
  endfunction

  task automatic check_dword(input string name, input l15_bridge_pkg::dword_t got,
                             input l15_bridge_pkg::dword_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("ERR %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_paddr(input string name, input l15_bridge_pkg::paddr_t got,
                             input l15_bridge_pkg::paddr_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("ERR %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_rqtype(input string name, input l15_bridge_pkg::rqtype_t got,
                              input l15_bridge_pkg::rqtype_t exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("ERR %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_rtntype(input string name, input l15_bridge_pkg::rtntype_e got,
                               input l15_bridge_pkg::rtntype_e exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("ERR %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_with_failure($sformatf("ERR %s got %h expected %h", name, got, exp));
    end
  endtask

  // Load, store ack and atomic stay on the data side
  function automatic logic wants_icache(input l15_bridge_pkg::rtntype_e t);
    case (t)
      l15_bridge_pkg::e_load_ret, l15_bridge_pkg::e_st_ack,
      l15_bridge_pkg::e_atomic_ret: return 1'b0;
      default: return 1'b1;
    endcase
  endfunction

  function automatic logic wants_dcache(input l15_bridge_pkg::rtntype_e t);
    return t != l15_bridge_pkg::e_ifill_ret;
  endfunction

  function automatic req_t random_req();
    req_t r;
    r.rqtype = l15_bridge_pkg::rqtype_t'(take_bits(5));
    r.nc = take_bits(1) != 64'd0;
    r.size = l15_bridge_pkg::size_t'(take_bits(3));
    r.address = l15_bridge_pkg::paddr_t'(take_bits(40));
    r.data = take_bits(64);
    r.l1rplway = l15_bridge_pkg::rplway_t'(take_bits(2));
    r.amo_op = l15_bridge_pkg::amo_op_t'(take_bits(4));
    return r;
  endfunction

  function automatic ret_t random_ret(input l15_bridge_pkg::rtntype_e t);
    ret_t r;
    r.rtntype = t;
    r.noncacheable = take_bits(1) != 64'd0;
    r.atomic = take_bits(1) != 64'd0;
    for (int i = 0; i < 4; i++) begin
      r.data[i] = take_bits(64);
    end
    r.inval_addr = l15_bridge_pkg::inval_addr_t'(take_bits(12));
    r.inval_icache = take_bits(1) != 64'd0;
    r.inval_dcache = take_bits(1) != 64'd0;
    r.inval_way = l15_bridge_pkg::way_t'(take_bits(2));
    return r;
  endfunction

  task automatic send_req(input logic to_dcache);
    req_t r;
    r = random_req();
    @(posedge clk);
    if (to_dcache) begin
      dcache_exp.push_back(r);
      dcache_in <= r;
      dcache_v <= 1'b1;
    end else begin
      icache_exp.push_back(r);
      icache_in <= r;
      icache_v <= 1'b1;
    end
    @(negedge clk);
    while (!(to_dcache ? dcache_ready : icache_ready)) begin
      @(negedge clk);
    end
    @(posedge clk);
    dcache_v <= 1'b0;
    icache_v <= 1'b0;
  endtask

  task automatic check_req_head(input req_t e);
    check_bit("l15_val_o", l15_val, 1'b1);
    check_rqtype("l15_rqtype_o", l15_rqtype, e.rqtype);
    check_bit("l15_nc_o", l15_nc, e.nc);
    check_paddr("l15_address_o", l15_address, e.address);
    check_dword("l15_data_o", l15_data, e.data);
    check_dword("l15_size_o/l15_l1rplway_o/l15_amo_op_o",
                l15_bridge_pkg::dword_t'({l15_size, l15_l1rplway, l15_amo_op}),
                l15_bridge_pkg::dword_t'({e.size, e.l1rplway, e.amo_op}));
  endtask

  // Data cache entries leave first, each on its own ack
  task automatic drain_reqs();
    req_t e;
    while (dcache_exp.size() + icache_exp.size() > 0) begin
      if (dcache_exp.size() > 0) begin
        e = dcache_exp.pop_front();
      end else begin
        e = icache_exp.pop_front();
      end
      @(negedge clk);
      check_req_head(e);
      @(posedge clk);
      ack <= 1'b1;
      @(posedge clk);
      ack <= 1'b0;
    end
    @(negedge clk);
    check_bit("l15_val_o", l15_val, 1'b0);
  endtask

  task automatic send_ret(input ret_t r);
    @(posedge clk);
    ret_in <= r;
    l15_ret_v <= 1'b1;
    @(negedge clk);
    while (!l15_req_ack) begin
      @(negedge clk);
    end
    @(posedge clk);
    l15_ret_v <= 1'b0;
  endtask

  task automatic consume_ret();
    ret_t e;
    logic use_dcache;
    e = ret_exp.pop_front();
    @(negedge clk);
    check_bit("icache_ret_v_o", icache_ret_v, wants_icache(e.rtntype));
    check_bit("dcache_ret_v_o", dcache_ret_v, wants_dcache(e.rtntype));
    check_rtntype("ret_rtntype_o", ret_rtntype, e.rtntype);
    check_bit("ret_noncacheable_o", ret_nc, e.noncacheable);
    check_bit("ret_atomic_o", ret_atomic, e.atomic);
    for (int i = 0; i < 4; i++) begin
      check_dword($sformatf("ret_data_%0d_o", i), ret_data[i], e.data[i]);
    end
    check_dword("ret_inval fields",
                l15_bridge_pkg::dword_t'({ret_iaddr, ret_iinv, ret_dinv, ret_way}),
                l15_bridge_pkg::dword_t'({e.inval_addr, e.inval_icache, e.inval_dcache,
                                          e.inval_way}));
    use_dcache = dcache_ret_v;
    @(posedge clk);
    if (use_dcache) begin
      dcache_yumi <= 1'b1;
    end else begin
      icache_yumi <= 1'b1;
    end
    @(posedge clk);
    dcache_yumi <= 1'b0;
    icache_yumi <= 1'b0;
  endtask

  task automatic test_reset_state();
    @(negedge clk);
    check_bit("l15_val_o", l15_val, 1'b0);
    check_bit("l15_req_ack_o", l15_req_ack, 1'b0);
    check_bit("icache_ret_v_o", icache_ret_v, 1'b0);
    check_bit("dcache_ret_v_o", dcache_ret_v, 1'b0);
    check_bit("icache_req_ready_o", icache_ready, 1'b1);
    check_bit("dcache_req_ready_o", dcache_ready, 1'b1);
  endtask

  task automatic test_single_req();
    req_t r;
    r = random_req();
    icache_exp.push_back(r);
    @(posedge clk);
    icache_in <= r;
    icache_v <= 1'b1;
    @(negedge clk);
    check_bit("icache_req_ready_o", icache_ready, 1'b1);
    // Registered queue, nothing shows up in the accepting cycle
    check_bit("l15_val_o", l15_val, 1'b0);
    @(posedge clk);
    icache_v <= 1'b0;
    repeat (3) begin
      @(negedge clk);
      check_req_head(icache_exp[0]);
    end
    drain_reqs();
  endtask

  task automatic test_priority();
    send_req(1'b0);
    send_req(1'b0);
    send_req(1'b1);
    send_req(1'b1);
    repeat (3) begin
      @(negedge clk);
      check_req_head(dcache_exp[0]);
    end
    drain_reqs();
  endtask

  task automatic test_req_full();
    for (int i = 0; i < `L15_REQ_FIFO_ELS; i++) begin
      @(negedge clk);
      check_bit("dcache_req_ready_o", dcache_ready, 1'b1);
      send_req(1'b1);
    end
    // One more request held valid must not get in
    @(posedge clk);
    dcache_in <= random_req();
    dcache_v <= 1'b1;
    repeat (3) begin
      @(negedge clk);
      check_bit("dcache_req_ready_o", dcache_ready, 1'b0);
      check_bit("icache_req_ready_o", icache_ready, 1'b1);
    end
    @(posedge clk);
    dcache_v <= 1'b0;
    drain_reqs();
  endtask

  task automatic test_ret_steering();
    ret_t r;
    for (int i = 0; i < 7; i++) begin
      r = random_ret(l15_bridge_pkg::rtntype_e'(type_codes[i]));
      ret_exp.push_back(r);
      send_ret(r);
    end
    while (ret_exp.size() > 0) begin
      consume_ret();
    end
    @(negedge clk);
    check_bit("icache_ret_v_o", icache_ret_v, 1'b0);
    check_bit("dcache_ret_v_o", dcache_ret_v, 1'b0);
  endtask

  task automatic test_ret_full();
    ret_t r;
    for (int i = 0; i < `L15_RET_FIFO_ELS; i++) begin
      r = random_ret(l15_bridge_pkg::rtntype_e'(type_codes[i % 7]));
      ret_exp.push_back(r);
      send_ret(r);
    end
    r = random_ret(l15_bridge_pkg::e_load_ret);
    @(posedge clk);
    ret_in <= r;
    l15_ret_v <= 1'b1;
    repeat (3) begin
      @(negedge clk);
      check_bit("l15_req_ack_o", l15_req_ack, 1'b0);
    end
    consume_ret();
    @(negedge clk);
    check_bit("l15_req_ack_o", l15_req_ack, 1'b1);
    @(posedge clk);
    l15_ret_v <= 1'b0;
    ret_exp.push_back(r);
    while (ret_exp.size() > 0) begin
      consume_ret();
    end
    @(negedge clk);
    check_bit("icache_ret_v_o", icache_ret_v, 1'b0);
    check_bit("dcache_ret_v_o", dcache_ret_v, 1'b0);
  endtask

  initial begin
    arst_n <= 1'b0;
    icache_in <= '0;
    dcache_in <= '0;
    icache_v <= 1'b0;
    dcache_v <= 1'b0;
    ack <= 1'b0;
    ret_in <= '0;
    l15_ret_v <= 1'b0;
    icache_yumi <= 1'b0;
    dcache_yumi <= 1'b0;
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    test_reset_state();
    test_single_req();
    test_priority();
    test_req_full();
    test_ret_steering();
    test_ret_full();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
+incdir+source
source/l15_bridge_pkg.sv
source/l15_msg_if.sv
source/bridge_fifo.sv
source/l15_req_arbiter.sv
source/l15_ret_router.sv
source/l15_bridge_top.sv
tests/tb_l15_bridge.sv

/* run.sh */
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing -f files.f --top-module tb_l15_bridge -o tb_l15_bridge \
  || { echo "build failed"; exit 1; }
./obj_dir/tb_l15_bridge > sim.log 2>&1 || echo "simulator returned a failing status"
grep -q "TESTBENCH PASSED" sim.log && echo "run passed" \
  || { echo "run failed, see sim.log"; exit 1; }
